/* common/act_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Leaky ReLU stage constants.
////////////////////////////////////////////////////////////////////////

package act_pkg;

	// Input strobe to multiplier output strobe, in clock cycles.
	parameter int MUL_LATENCY = 7;

	// Whole stage. Multiplier plus the selector output register.
	parameter int STAGE_LATENCY = MUL_LATENCY + 1;

	// Default slope for negative inputs, about 0.1.
	parameter logic [31:0] DEFAULT_ALPHA = 32'h3DCCCCCD;

endpackage

`default_nettype wire

/* common/fp32_pkg.sv */
`default_nettype none

////////////////////////////////////////////////////////////////////////
// IEEE-754 binary32 format description.
////////////////////////////////////////////////////////////////////////

package fp32_pkg;

	parameter int EXP_WIDTH  = 8;   // Biased exponent field.
	parameter int MANT_WIDTH = 23;  // Stored fraction, hidden bit not included.
	parameter int EXP_BIAS   = 127;

	// Field order matches the bit order of the word, sign in bit 31.
	typedef struct packed {
		logic                  sign;
		logic [EXP_WIDTH-1:0]  exp;
		logic [MANT_WIDTH-1:0] mant;
	} fp32_fields_t;

	// One word with two views.
	// bits is what travels on ports, f is the decoded form.
	typedef union packed {
		logic [31:0]  bits;
		fp32_fields_t f;
	} fp32_word_u;

endpackage

`default_nettype wire

/* filelist.f */
+incdir+verif
common/fp32_pkg.sv
common/act_pkg.sv
fp32_multiplier/fp32_scale_multiplier.sv
source/act_bypass_delay.sv
source/act_result_select.sv
source/leakyrelu_unit.sv
verif/tb_leakyrelu_unit.sv

/* fp32_multiplier/fp32_scale_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Binary32 multiply by a constant factor, seven register stages.
// Zero and subnormal operands or products flush to a signed zero.
// The product is truncated, exponent overflow gives a signed infinity.
////////////////////////////////////////////////////////////////////////

module fp32_scale_multiplier #(
	parameter logic [31:0] SCALE = 32'h3F800000
) (
	input  wire         clk,
	input  wire         rst_n,
	input  logic        i_valid,
	input  logic [31:0] i_data,
	output logic        o_valid,
	output logic [31:0] o_data
);

	localparam int EW      = fp32_pkg::EXP_WIDTH;
	localparam int MW      = fp32_pkg::MANT_WIDTH;
	localparam int ES      = EW + 2;          // Signed exponent with headroom.
	localparam int PW      = 2 * (MW + 1);    // Full mantissa product.
	localparam int HALF    = (MW + 1) / 2;    // Split point of the constant.
	localparam int PPW     = MW + 1 + HALF;   // Partial product width.
	localparam int EXP_MAX = (1 << EW) - 1;
	localparam int LAT     = act_pkg::MUL_LATENCY;

	// Constant operand, decoded once at elaboration.
	localparam fp32_pkg::fp32_word_u SCALE_W = SCALE;
	localparam logic              SCALE_SIGN = SCALE_W.f.sign;
	localparam logic signed [ES-1:0] SCALE_EXP = {2'b00, SCALE_W.f.exp};
	localparam logic [MW:0]       SCALE_MANT = {1'b1, SCALE_W.f.mant};
	localparam logic signed [ES-1:0] BIAS = ES'(fp32_pkg::EXP_BIAS);

	logic [LAT-1:0] vld;  // Valid strobe, one bit per stage.

	fp32_pkg::fp32_word_u in_w;
	fp32_pkg::fp32_word_u out_w;

	// Stage 1, unpacked operand.
	logic        s1_sign;
	logic [EW-1:0] s1_exp;
	logic [MW:0] s1_mant;
	logic        s1_zero;

	// Stage 2, sign and exponent sum.
	logic        s2_sign;
	logic signed [ES-1:0] s2_exp;
	logic [MW:0] s2_mant;
	logic        s2_zero;

	// Stage 3, two partial products.
	logic        s3_sign;
	logic signed [ES-1:0] s3_exp;
	logic [PPW-1:0] s3_p_lo;
	logic [PPW-1:0] s3_p_hi;
	logic        s3_zero;

	// Stage 4, full product.
	logic        s4_sign;
	logic signed [ES-1:0] s4_exp;
	logic [PW-1:0] s4_prod;
	logic        s4_zero;

	// Stage 5, normalized.
	logic        s5_sign;
	logic signed [ES-1:0] s5_exp;
	logic [MW-1:0] s5_mant;
	logic        s5_zero;

	// Stage 6, range checked.
	logic        s6_sign;
	logic [EW-1:0] s6_exp;
	logic [MW-1:0] s6_mant;

	always_comb begin
		in_w.bits = i_data;
	end

	always_comb begin
		out_w.f.sign = s6_sign;
		out_w.f.exp  = s6_exp;
		out_w.f.mant = s6_mant;
	end

	////////////////////////////////////////////////////////////////////
	// Valid pipeline.
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld <= '0;
		end else begin
			vld <= {vld[LAT-2:0], i_valid};
		end
	end

	assign o_valid = vld[LAT-1];

	////////////////////////////////////////////////////////////////////
	// Data pipeline.
	////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		// 1. Unpack, hidden bit restored.
		s1_sign <= in_w.f.sign;
		s1_exp  <= in_w.f.exp;
		s1_mant <= {1'b1, in_w.f.mant};
		s1_zero <= (in_w.f.exp == '0);  // Zero or subnormal input.

		// 2. Result sign and unbiased exponent sum.
		s2_sign <= s1_sign ^ SCALE_SIGN;
		s2_exp  <= $signed({2'b00, s1_exp}) + SCALE_EXP - BIAS;
		s2_mant <= s1_mant;
		s2_zero <= s1_zero;

		// 3. Low and high halves of the constant.
		s3_sign <= s2_sign;
		s3_exp  <= s2_exp;
		s3_p_lo <= s2_mant * SCALE_MANT[HALF-1:0];
		s3_p_hi <= s2_mant * SCALE_MANT[MW:HALF];
		s3_zero <= s2_zero;

		// 4. Sum of the shifted partial products.
		s4_sign <= s3_sign;
		s4_exp  <= s3_exp;
		s4_prod <= {s3_p_hi, {HALF{1'b0}}} + PW'(s3_p_lo);
		s4_zero <= s3_zero;

		// 5. Product is in [1, 4), shift by at most one bit.
		s5_sign <= s4_sign;
		s5_exp  <= s4_exp + {{(ES-1){1'b0}}, s4_prod[PW-1]};
		if (s4_prod[PW-1]) begin
			s5_mant <= s4_prod[PW-2 -: MW];
		end else begin
			s5_mant <= s4_prod[PW-3 -: MW];  // Low bits dropped, truncation.
		end
		s5_zero <= s4_zero;

		// 6. Flush and saturate.
		s6_sign <= s5_sign;
		if (s5_zero || s5_exp <= 0) begin
			s6_exp  <= '0;
			s6_mant <= '0;
		end else if (s5_exp >= EXP_MAX) begin
			s6_exp  <= '1;  // Infinity.
			s6_mant <= '0;
		end else begin
			s6_exp  <= s5_exp[EW-1:0];
			s6_mant <= s5_mant;
		end

		// 7. Pack.
		o_data <= out_w.bits;
	end

	// Every accepted word leaves exactly MUL_LATENCY cycles later.
	a_latency_fwd: assert property (@(posedge clk) disable iff (!rst_n)
		i_valid |-> ##LAT o_valid)
		else $error("multiplier lost a valid strobe");

	a_latency_back: assert property (@(posedge clk) disable iff (!rst_n)
		o_valid |-> $past(i_valid, LAT))
		else $error("multiplier produced a spurious valid strobe");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# Build and run the leaky ReLU testbench with Verilator.
# The exit status is the simulator's own, non-zero on failure.
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f filelist.f \
	--top-module tb_leakyrelu_unit \
	--Mdir obj_dir \
	-o sim_leakyrelu

./obj_dir/sim_leakyrelu

/* source/act_bypass_delay.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Bypass path. Carries the original word beside the multiplier.
////////////////////////////////////////////////////////////////////////

module act_bypass_delay (
	input  wire         clk,
	input  wire         rst_n,
	input  logic        i_valid,
	input  logic [31:0] i_data,
	output logic        o_valid,
	output logic [31:0] o_data,
	output logic        o_take_scaled
);

	localparam int LAT = act_pkg::MUL_LATENCY;

	fp32_pkg::fp32_word_u in_w;

	logic [LAT-1:0]       vld;
	logic [LAT-1:0]       take;
	logic [LAT-1:0][31:0] word;
	logic                 take_in;

	always_comb begin
		in_w.bits = i_data;
	end

	// Negative and normal. Negative zero and subnormals pass unchanged.
	assign take_in = in_w.f.sign && (in_w.f.exp != {fp32_pkg::EXP_WIDTH{1'b0}});

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			vld <= '0;
		end else begin
			vld <= {vld[LAT-2:0], i_valid};
		end
	end

	always_ff @(posedge clk) begin
		take <= {take[LAT-2:0], take_in};
		word <= {word[LAT-2:0], in_w.bits};
	end

	assign o_valid       = vld[LAT-1];
	assign o_take_scaled = take[LAT-1];
	assign o_data        = word[LAT-1];

endmodule

`default_nettype wire

/* source/act_result_select.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Output stage. Picks scaled or original word and registers it.
////////////////////////////////////////////////////////////////////////

module act_result_select (
	input  wire         clk,
	input  wire         rst_n,
	input  logic        i_mul_valid,
	input  logic [31:0] i_mul_data,
	input  logic        i_dly_valid,
	input  logic [31:0] i_dly_data,
	input  logic        i_take_scaled,
	output logic        o_valid,
	output logic [31:0] o_data
);

	logic item;  // An item sits in the output slot this cycle.

	assign item = i_mul_valid & i_dly_valid;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_valid <= 1'b0;
			o_data  <= '0;
		end else if (item) begin
			o_valid <= 1'b1;
			o_data  <= i_take_scaled ? i_mul_data : i_dly_data;
		end else begin
			o_valid <= 1'b0;
			o_data  <= '0;  // Idle output is zero.
		end
	end

	////////////////////////////////////////////////////////////////////
	// Path alignment checks.
	////////////////////////////////////////////////////////////////////

	// Multiplier and delay line must stay in lock step.
	a_paths_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		i_mul_valid == i_dly_valid)
		else $error("scaled and bypass paths out of step");

	a_idle_zero: assert property (@(posedge clk) disable iff (!rst_n)
		!o_valid |-> (o_data == '0))
		else $error("output not zero while idle");

endmodule

`default_nettype wire

/* source/leakyrelu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

////////////////////////////////////////////////////////////////////////
// Leaky ReLU on binary32 words.
// Output is x for non-negative x and ALPHA * x for negative normal x.
// Latency is act_pkg::STAGE_LATENCY cycles, one item per cycle,
// no back-pressure.
////////////////////////////////////////////////////////////////////////

module leakyrelu_unit #(
	parameter logic [31:0] ALPHA = act_pkg::DEFAULT_ALPHA
) (
	input  wire         clk,
	input  wire         rst_n,
	input  logic        i_valid,
	input  logic [31:0] i_data,
	output logic        o_valid,
	output logic [31:0] o_data
);

	logic        mul_valid;
	logic [31:0] mul_data;
	logic        dly_valid;
	logic [31:0] dly_data;
	logic        dly_take_scaled;

	// Scaled path.
	fp32_scale_multiplier #(
		.SCALE (ALPHA)
	) u_mul (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (i_valid),
		.i_data  (i_data),
		.o_valid (mul_valid),
		.o_data  (mul_data)
	);

	// Original word and path choice, same latency.
	act_bypass_delay u_dly (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_valid       (i_valid),
		.i_data        (i_data),
		.o_valid       (dly_valid),
		.o_data        (dly_data),
		.o_take_scaled (dly_take_scaled)
	);

	act_result_select u_sel (
		.clk           (clk),
		.rst_n         (rst_n),
		.i_mul_valid   (mul_valid),
		.i_mul_data    (mul_data),
		.i_dly_valid   (dly_valid),
		.i_dly_data    (dly_data),
		.i_take_scaled (dly_take_scaled),
		.o_valid       (o_valid),
		.o_data        (o_data)
	);

endmodule

`default_nettype wire

/* verif/tb_fp32_model.svh */
`ifndef TB_FP32_MODEL_SVH
`define TB_FP32_MODEL_SVH

////////////////////////////////////////////////////////////////////////
// Reference arithmetic for the leaky ReLU stage.
////////////////////////////////////////////////////////////////////////

// Binary32 product of a word and a normal factor.
// Zero or subnormal operand gives a signed zero.
// Fraction bits below the result are dropped.
// A result below the normal range flushes, one above it saturates.
function automatic logic [31:0] scale_product(input logic [31:0] x, input logic [31:0] s);
	logic        sign;
	int          exp_sum;
	logic [47:0] prod;
	logic [22:0] frac;
	sign = x[31] ^ s[31];
	if (x[30:23] == 8'd0) begin
		return {sign, 31'd0};
	end
	prod = 48'({1'b1, x[22:0]}) * 48'({1'b1, s[22:0]});
	exp_sum = int'(x[30:23]) + int'(s[30:23]) - fp32_pkg::EXP_BIAS;
	if (prod[47]) begin
		exp_sum = exp_sum + 1;  // Significand product in [2, 4).
		frac    = prod[46:24];
	end else begin
		frac = prod[45:23];
	end
	if (exp_sum <= 0) begin
		return {sign, 31'd0};
	end
	if (exp_sum >= 255) begin
		return {sign, 8'hFF, 23'd0};  // Signed infinity.
	end
	return {sign, exp_sum[7:0], frac};
endfunction

// Negative normal words take the slope, all others pass as they are.
// Negative zero and negative subnormals keep their own bits.
function automatic logic [31:0] leaky_relu(input logic [31:0] x, input logic [31:0] alpha);
	logic negative_normal;
	negative_normal = x[31] && (x[30:23] != 8'd0);
	if (negative_normal) begin
		return scale_product(x, alpha);
	end
	return x;
endfunction

// 32-bit xorshift step, shifts 13, 17, 5.
function automatic logic [31:0] xorshift32(input logic [31:0] state);
	logic [31:0] s;
	s = state;
	s = s ^ (s << 13);
	s = s ^ (s >> 17);
	s = s ^ (s << 5);
	return s;
endfunction

`endif

/* verif/tb_leakyrelu_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_leakyrelu_unit;

	localparam logic [31:0] SLOPE = act_pkg::DEFAULT_ALPHA;
	localparam int LATENCY         = act_pkg::STAGE_LATENCY;
	localparam int WATCHDOG_CYCLES = 5000;
	localparam int DRAIN_CYCLES    = 4 * act_pkg::STAGE_LATENCY;

	// Signs, zeros, subnormals, underflow and range ends in one burst.
	localparam logic [31:0] DIRECTED [13] = '{
		32'h3F800000, 32'h00000000, 32'hBF800000, 32'h80000000,
		32'h80000001, 32'h00000001, 32'h80800000, 32'hC0600000,
		32'h7F7FFFFF, 32'hFF7FFFFF, 32'h42C80000, 32'hC2C80000,
		32'h81000000
	};

	logic        clk = 1'b0;
	logic        rst_n;
	logic        i_valid;
	logic [31:0] i_data;
	logic        o_valid;
	logic [31:0] o_data;

	logic [31:0] rng_state = 32'd61;
	int          edge_count = 0;
	logic        chk_valid = 1'b0;   // An output is due in this slot.
	logic [31:0] chk_data = 32'h0;

	logic [31:0] exp_data_q [$];
	int          exp_due_q [$];     // Edge count at which each item is due.

	`include "tb_fp32_model.svh"

	leakyrelu_unit dut0 (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_valid (i_valid),
		.i_data  (i_data),
		.o_valid (o_valid),
		.o_data  (o_data)
	);

	always #50 clk = ~clk;

	always @(posedge clk) begin
		edge_count <= edge_count + 1;
	end

	////////////////////////////////////////////////////////////////////
	// Scoreboard, head of queue moves into the check slot.
	////////////////////////////////////////////////////////////////////

	// Loaded on the falling edge before the edge at which the item is due.
	always @(negedge clk) begin
		if (exp_due_q.size() > 0 && exp_due_q[0] == edge_count + 1) begin
			chk_valid <= 1'b1;
			chk_data  <= exp_data_q.pop_front();
			void'(exp_due_q.pop_front());
		end else begin
			chk_valid <= 1'b0;
			chk_data  <= 32'h0;
		end
	end

	task automatic stop_with_failure(input string reason);
		$display("%s", reason);
		$display("sim failed");
		$fatal(1, "testbench stopped at first error");
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("[FAIL] t=%0t ns %s expected %h got %h", $time, name, expected, actual);
		stop_with_failure("output mismatch");
	endtask

	a_valid_match: assert property (@(posedge clk) o_valid == chk_valid)
		else report_mismatch("o_valid", 32'($sampled(chk_valid)), 32'($sampled(o_valid)));

	a_data_match: assert property (@(posedge clk) chk_valid |-> (o_data == chk_data))
		else report_mismatch("o_data", $sampled(chk_data), $sampled(o_data));

	a_idle_zero: assert property (@(posedge clk) !o_valid |-> (o_data == 32'h0))
		else report_mismatch("o_data", 32'h0, $sampled(o_data));

	////////////////////////////////////////////////////////////////////
	// Stimulus.
	////////////////////////////////////////////////////////////////////

	// Item is sampled at the next edge and due LATENCY edges later.
	task automatic send_item(input logic [31:0] word);
		@(posedge clk);
		#1;
		i_valid = 1'b1;
		i_data  = word;
		exp_data_q.push_back(leaky_relu(word, SLOPE));
		exp_due_q.push_back(edge_count + 1 + LATENCY);
	endtask

	task automatic idle_cycles(input int count);
		for (int i = 0; i < count; i++) begin
			@(posedge clk);
			#1;
			i_valid = 1'b0;
			i_data  = 32'h0;
		end
	endtask

	// Exponent 100 to 150, so products stay normal.
	task automatic random_word(input bit positive, output logic [31:0] word);
		logic [31:0] r_exp;
		logic [31:0] r_mant;
		logic [7:0]  biased;
		rng_state = xorshift32(rng_state);
		r_exp     = rng_state;
		rng_state = xorshift32(rng_state);
		r_mant    = rng_state;
		biased    = 8'(100 + (r_exp % 51));
		word      = {r_exp[31] & !positive, biased, r_mant[22:0]};
	endtask

	task automatic drain_queue(input int limit, output bit drained);
		int n;
		n = 0;
		while (exp_data_q.size() != 0 && n < limit) begin
			@(posedge clk);
			n = n + 1;
		end
		drained = (exp_data_q.size() == 0);
	endtask

	initial begin
		for (int i = 0; i < WATCHDOG_CYCLES; i++) begin
			@(posedge clk);
		end
		stop_with_failure("watchdog expired before the test finished");
	end

	initial begin
		bit          drained;
		logic [31:0] word;
		int          gap;
		rst_n   = 1'b1;
		i_valid = 1'b0;
		i_data  = 32'h0;
		#1 rst_n = 1'b0;
		for (int i = 0; i < 10; i++) begin
			@(posedge clk);
		end
		#1 rst_n = 1'b1;
		idle_cycles(LATENCY + 2);  // Outputs stay idle after reset.

		for (int i = 0; i < 20; i++) begin
			random_word(1'b1, word);
			send_item(word);
		end
		idle_cycles(3);

		foreach (DIRECTED[i]) begin
			send_item(DIRECTED[i]);
		end
		idle_cycles(2);

		// Full rate, one item every cycle.
		for (int i = 0; i < 200; i++) begin
			random_word(1'b0, word);
			send_item(word);
		end
		idle_cycles(5);

		for (int i = 0; i < 100; i++) begin
			random_word(1'b0, word);
			send_item(word);
			rng_state = xorshift32(rng_state);
			gap = int'(rng_state % 4);
			idle_cycles(gap);
		end
		idle_cycles(1);

		drain_queue(DRAIN_CYCLES, drained);
		idle_cycles(2);
		if (drained) begin
			$display("sim passed");
			$finish;
		end else begin
			$display("expected outputs still pending after drain timeout");
			$display("sim failed");
			$fatal(1, "queue not drained");
		end
	end

endmodule

`default_nettype wire
